/* src/sa_geom_pkg.sv */
`default_nettype none

package sa_geom_pkg;

  // ---------------------------------------------------------------------
  // Router geometry seen by one output port
  // ---------------------------------------------------------------------
  localparam int NUM_PORTS = 5;                   // L, N, W, S, E
  localparam int NUM_VN    = 3;                   // Virtual networks
  localparam int NUM_VC    = 2;                   // VCs inside each VN
  localparam int NUM_SLOTS = NUM_VN * NUM_VC;     // VN x VC slots per port
  localparam int NUM_REQ   = NUM_PORTS * NUM_SLOTS; // Request bits, all ports

  // Index widths
  localparam int PORT_W   = 3;
  localparam int VN_W     = 2;
  localparam int VC_W     = 1;
  localparam int SLOT_W   = 3;
  localparam int REQ_W    = 5;
  localparam int ASSIGN_W = REQ_W + 1;            // All ones marks a free slot

  // Input port order, request bit = port*NUM_SLOTS + vn*NUM_VC + vc
  localparam int PORT_L     = 0;
  localparam int PORT_N     = 1;
  localparam int PORT_W_IDX = 2;
  localparam int PORT_S     = 3;
  localparam int PORT_E     = 4;

endpackage

`default_nettype wire

/* src/sa_weight_pkg.sv */
`default_nettype none

package sa_weight_pkg;

  // ---------------------------------------------------------------------
  // VN weight schedule
  // ---------------------------------------------------------------------

  // Number of entries, visited in order, one step per grant
  localparam int WEIGHT_LEN = 10;

  // Pointer into the schedule, wraps from WEIGHT_LEN-1 to 0
  localparam int WEIGHT_PTR_W = 4;

  // Entry k holds a VN number at bits k*VN_W upward
  localparam int WEIGHT_VEC_W = WEIGHT_LEN * sa_geom_pkg::VN_W;

endpackage

`default_nettype wire

/* src/sa_rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// Round-robin arbiter, search starts one past the last winner
module sa_rr_arbiter #(
  parameter int N = 4
) (
  input  wire logic            clk,
  input  wire logic            rst_p,
  input  wire logic [N-1:0]    req,
  input  wire logic            upd,    // Winner becomes the new pointer
  output logic [N-1:0]         gnt,    // One-hot, zero when idle
  output logic [$clog2(N)-1:0] gnt_id,
  output logic                 any     // At least one requester
);

  localparam int ID_W = $clog2(N);

  logic [ID_W-1:0] ptr;  // Last winner

  // ---------------------------------------------------------------------
  // Cyclic search
  // ---------------------------------------------------------------------
  always_comb begin
    int   idx;
    logic found;
    found  = 1'b0;
    gnt    = '0;
    gnt_id = '0;
    idx    = 0;
    for (int k = 1; k <= N; k++) begin
      idx = (int'(ptr) + k) % N;  // Wraps past the top index
      if (!found && req[idx]) begin
        found    = 1'b1;
        gnt[idx] = 1'b1;
        gnt_id   = idx[ID_W-1:0];
      end
    end
  end

  assign any = |req;

  // Pointer starts at the top so index 0 is searched first
  always_ff @(posedge clk) begin
    if (rst_p) begin
      ptr <= ID_W'(N - 1);
    end else if (upd) begin
      ptr <= gnt_id;
    end
  end

endmodule

`default_nettype wire

/* src/sa_req_filter.sv */
`timescale 1ns/1ps
`default_nettype none

// Request qualification against VC ownership and flow control
module sa_req_filter (
  input  wire logic [sa_geom_pkg::NUM_REQ-1:0]                       req,
  input  wire logic [sa_geom_pkg::NUM_SLOTS-1:0]                     sg,
  input  wire logic [sa_geom_pkg::NUM_SLOTS*sa_geom_pkg::ASSIGN_W-1:0] vc_assigns,
  input  wire logic                                                  go_phit,
  output logic [sa_geom_pkg::NUM_REQ-1:0]                            eligible,
  output logic [sa_geom_pkg::NUM_REQ*sa_geom_pkg::SLOT_W-1:0]        slot_vc
);

  // ---------------------------------------------------------------------
  // Per request bit, search the assignment table for its owner entry
  // ---------------------------------------------------------------------
  for (genvar i = 0; i < sa_geom_pkg::NUM_REQ; i++) begin : g_req
    logic                           hit;   // Some downstream slot belongs to us
    logic [sa_geom_pkg::SLOT_W-1:0] slot;  // That slot, zero if none

    always_comb begin
      int d_hit;
      d_hit = -1;
      for (int d = 0; d < sa_geom_pkg::NUM_SLOTS; d++) begin
        // Free entries are all ones and never match a request index
        if (d_hit < 0 &&
            int'(vc_assigns[d*sa_geom_pkg::ASSIGN_W +: sa_geom_pkg::ASSIGN_W]) == i) begin
          d_hit = d;
        end
      end
      hit  = (d_hit >= 0);
      slot = hit ? d_hit[sa_geom_pkg::SLOT_W-1:0] : '0;
    end

    assign slot_vc[i*sa_geom_pkg::SLOT_W +: sa_geom_pkg::SLOT_W] = slot;

    // Owner found, downstream VC open, output stage ready
    assign eligible[i] = req[i] & hit & sg[slot] & go_phit;
  end

endmodule

`default_nettype wire

/* src/sa_port_arb.sv */
`timescale 1ns/1ps
`default_nettype none

// First level, pick one input port per VN x VC slot
module sa_port_arb (
  input  wire logic                                              clk,
  input  wire logic                                              rst_p,
  input  wire logic [sa_geom_pkg::NUM_REQ-1:0]                   eligible,
  input  wire logic [sa_geom_pkg::NUM_SLOTS-1:0]                 slot_upd,
  output logic [sa_geom_pkg::NUM_SLOTS-1:0]                      slot_cand,
  output logic [sa_geom_pkg::NUM_SLOTS*sa_geom_pkg::PORT_W-1:0]  slot_port
);

  for (genvar s = 0; s < sa_geom_pkg::NUM_SLOTS; s++) begin : g_slot
    logic [sa_geom_pkg::NUM_PORTS-1:0] port_req;  // Bit p = port p wants slot s

    // Regroup, request vector is ordered port-major
    for (genvar p = 0; p < sa_geom_pkg::NUM_PORTS; p++) begin : g_port
      assign port_req[p] = eligible[p*sa_geom_pkg::NUM_SLOTS + s];
    end

    sa_rr_arbiter #(
      .N      (sa_geom_pkg::NUM_PORTS)
    ) port_rr_i (
      .clk    (clk),
      .rst_p  (rst_p),
      .req    (port_req),
      .upd    (slot_upd[s]),                   // Only when this slot wins overall
      .gnt    (),                              // Index form is enough here
      .gnt_id (slot_port[s*sa_geom_pkg::PORT_W +: sa_geom_pkg::PORT_W]),
      .any    (slot_cand[s])
    );
  end

endmodule

`default_nettype wire

/* src/sa_vn_arb.sv */
`timescale 1ns/1ps
`default_nettype none

// Second level VC choice per VN, plus the fallback VN round-robin
module sa_vn_arb (
  input  wire logic                                         clk,
  input  wire logic                                         rst_p,
  input  wire logic [sa_geom_pkg::NUM_SLOTS-1:0]            slot_cand,
  input  wire logic [sa_geom_pkg::NUM_VN-1:0]               vn_upd,
  input  wire logic                                         fb_upd,
  output logic [sa_geom_pkg::NUM_VN-1:0]                    vn_cand,
  output logic [sa_geom_pkg::NUM_VN*sa_geom_pkg::VC_W-1:0]  vn_vc,
  output logic [sa_geom_pkg::VN_W-1:0]                      fb_vn
);

  // ---------------------------------------------------------------------
  // VC arbiters, one per VN
  // ---------------------------------------------------------------------
  for (genvar v = 0; v < sa_geom_pkg::NUM_VN; v++) begin : g_vn
    sa_rr_arbiter #(
      .N      (sa_geom_pkg::NUM_VC)
    ) vc_rr_i (
      .clk    (clk),
      .rst_p  (rst_p),
      .req    (slot_cand[v*sa_geom_pkg::NUM_VC +: sa_geom_pkg::NUM_VC]),  // Slots of VN v
      .upd    (vn_upd[v]),
      .gnt    (),
      .gnt_id (vn_vc[v*sa_geom_pkg::VC_W +: sa_geom_pkg::VC_W]),
      .any    (vn_cand[v])                                            // VN has work
    );
  end

  // ---------------------------------------------------------------------
  // Fallback among VNs with candidates
  // ---------------------------------------------------------------------
  // Used only when the weighted VN is empty; otherwise its pointer
  // stays put
  sa_rr_arbiter #(
    .N      (sa_geom_pkg::NUM_VN)
  ) fb_rr_i (
    .clk    (clk),
    .rst_p  (rst_p),
    .req    (vn_cand),
    .upd    (fb_upd),
    .gnt    (),
    .gnt_id (fb_vn),
    .any    ()       // Same as the OR of vn_cand, known in the controller
  );

endmodule

`default_nettype wire

/* src/sa_alloc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Final VN choice from the weight schedule, and arbiter update enables
module sa_alloc_ctrl (
  input  wire logic                                        clk,
  input  wire logic                                        rst_p,
  input  wire logic [sa_weight_pkg::WEIGHT_VEC_W-1:0]      weights,
  input  wire logic [sa_geom_pkg::NUM_VN-1:0]              vn_cand,
  input  wire logic [sa_geom_pkg::NUM_VN*sa_geom_pkg::VC_W-1:0] vn_vc,
  input  wire logic [sa_geom_pkg::VN_W-1:0]                fb_vn,
  output logic                                             win_valid,
  output logic [sa_geom_pkg::VN_W-1:0]                     win_vn,
  output logic [sa_geom_pkg::VC_W-1:0]                     win_vc,
  output logic [sa_geom_pkg::NUM_SLOTS-1:0]                slot_upd,
  output logic [sa_geom_pkg::NUM_VN-1:0]                   vn_upd,
  output logic                                             fb_upd
);

  logic [sa_weight_pkg::WEIGHT_PTR_W-1:0] wptr;   // Current schedule entry
  logic [sa_geom_pkg::VN_W-1:0]           w_vn;   // VN named by that entry
  logic                                   w_hit;  // Weighted VN has a candidate

  assign w_vn = weights[wptr*sa_geom_pkg::VN_W +: sa_geom_pkg::VN_W];

  // ---------------------------------------------------------------------
  // Winner selection
  // ---------------------------------------------------------------------
  always_comb begin
    w_hit = 1'b0;
    for (int v = 0; v < sa_geom_pkg::NUM_VN; v++) begin
      if (int'(w_vn) == v) w_hit = vn_cand[v];  // Entry naming no VN never hits
    end
  end

  assign win_valid = |vn_cand;
  assign win_vn    = w_hit ? w_vn : fb_vn;   // Fallback only if weighted is empty
  assign fb_upd    = win_valid & ~w_hit;

  always_comb begin
    int slot_i;
    win_vc = '0;
    for (int v = 0; v < sa_geom_pkg::NUM_VN; v++) begin
      if (int'(win_vn) == v) win_vc = vn_vc[v*sa_geom_pkg::VC_W +: sa_geom_pkg::VC_W];
    end
    slot_i = int'(win_vn) * sa_geom_pkg::NUM_VC + int'(win_vc);
    // Only the path of the final winner moves its pointers
    for (int s = 0; s < sa_geom_pkg::NUM_SLOTS; s++) begin
      slot_upd[s] = win_valid && (s == slot_i);
    end
    for (int v = 0; v < sa_geom_pkg::NUM_VN; v++) begin
      vn_upd[v] = win_valid && (int'(win_vn) == v);
    end
  end

  // Weight pointer, one step per grant
  always_ff @(posedge clk) begin
    if (rst_p) begin
      wptr <= '0;
    end else if (win_valid) begin
      if (int'(wptr) == sa_weight_pkg::WEIGHT_LEN - 1) wptr <= '0;
      else wptr <= wptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/sa_grant_out.sv */
`timescale 1ns/1ps
`default_nettype none

// Grant register stage
module sa_grant_out (
  input  wire logic                                              clk,
  input  wire logic                                              rst_p,
  input  wire logic                                              win_valid,
  input  wire logic [sa_geom_pkg::VN_W-1:0]                      win_vn,
  input  wire logic [sa_geom_pkg::VC_W-1:0]                      win_vc,
  input  wire logic [sa_geom_pkg::NUM_SLOTS*sa_geom_pkg::PORT_W-1:0] slot_port,
  input  wire logic [sa_geom_pkg::NUM_REQ*sa_geom_pkg::SLOT_W-1:0]   slot_vc,
  output logic [sa_geom_pkg::NUM_REQ-1:0]                        grants,
  output logic [sa_geom_pkg::SLOT_W-1:0]                         vc_selected
);

  logic [sa_geom_pkg::NUM_REQ-1:0] grant_nxt;  // One-hot or zero
  logic [sa_geom_pkg::SLOT_W-1:0]  vc_nxt;     // Downstream slot of the winner

  // ---------------------------------------------------------------------
  // Winning request index = port*NUM_SLOTS + vn*NUM_VC + vc
  // ---------------------------------------------------------------------
  always_comb begin
    int slot_i;
    int port_i;
    int req_i;
    slot_i = int'(win_vn) * sa_geom_pkg::NUM_VC + int'(win_vc);
    port_i = int'(slot_port[slot_i*sa_geom_pkg::PORT_W +: sa_geom_pkg::PORT_W]);
    req_i  = port_i * sa_geom_pkg::NUM_SLOTS + slot_i;
    grant_nxt = '0;
    if (win_valid) grant_nxt[req_i] = 1'b1;
    vc_nxt = slot_vc[req_i*sa_geom_pkg::SLOT_W +: sa_geom_pkg::SLOT_W];
  end

  always_ff @(posedge clk) begin
    if (rst_p) begin
      grants      <= '0;
      vc_selected <= '0;
    end else begin
      grants <= grant_nxt;                  // Drops to zero on an idle cycle
      if (win_valid) vc_selected <= vc_nxt; // Holds otherwise
    end
  end

endmodule

`default_nettype wire

/* src/sa_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Switch allocation for one non-local output port
module sa_top (
  input  wire logic                                                  clk,
  input  wire logic                                                  rst_p,
  input  wire logic [sa_geom_pkg::NUM_REQ-1:0]                       req,
  input  wire logic [sa_geom_pkg::NUM_SLOTS-1:0]                     sg,
  input  wire logic [sa_geom_pkg::NUM_SLOTS*sa_geom_pkg::ASSIGN_W-1:0] vc_assigns,
  input  wire logic [sa_weight_pkg::WEIGHT_VEC_W-1:0]                weights,
  input  wire logic                                                  go_phit,
  output logic [sa_geom_pkg::NUM_REQ-1:0]                            grants,
  output logic [sa_geom_pkg::SLOT_W-1:0]                             vc_selected
);

  // ---------------------------------------------------------------------
  // Internal nets
  // ---------------------------------------------------------------------
  logic [sa_geom_pkg::NUM_REQ-1:0]                      eligible;
  logic [sa_geom_pkg::NUM_REQ*sa_geom_pkg::SLOT_W-1:0]  slot_vc;    // Downstream slot per req
  logic [sa_geom_pkg::NUM_SLOTS-1:0]                    slot_cand;
  logic [sa_geom_pkg::NUM_SLOTS*sa_geom_pkg::PORT_W-1:0] slot_port; // Port winner per slot
  logic [sa_geom_pkg::NUM_VN-1:0]                       vn_cand;
  logic [sa_geom_pkg::NUM_VN*sa_geom_pkg::VC_W-1:0]     vn_vc;      // VC winner per VN
  logic [sa_geom_pkg::VN_W-1:0]                         fb_vn;
  logic                                                 win_valid;
  logic [sa_geom_pkg::VN_W-1:0]                         win_vn;
  logic [sa_geom_pkg::VC_W-1:0]                         win_vc;
  logic [sa_geom_pkg::NUM_SLOTS-1:0]                    slot_upd;
  logic [sa_geom_pkg::NUM_VN-1:0]                       vn_upd;
  logic                                                 fb_upd;

  sa_req_filter req_filter_i (
    .req        (req),
    .sg         (sg),
    .vc_assigns (vc_assigns),
    .go_phit    (go_phit),
    .eligible   (eligible),
    .slot_vc    (slot_vc)
  );

  sa_port_arb port_arb_i (
    .clk       (clk),
    .rst_p     (rst_p),
    .eligible  (eligible),
    .slot_upd  (slot_upd),
    .slot_cand (slot_cand),
    .slot_port (slot_port)
  );

  sa_vn_arb vn_arb_i (
    .clk       (clk),
    .rst_p     (rst_p),
    .slot_cand (slot_cand),
    .vn_upd    (vn_upd),
    .fb_upd    (fb_upd),
    .vn_cand   (vn_cand),
    .vn_vc     (vn_vc),
    .fb_vn     (fb_vn)
  );

  // Controller closes the loop back into the arbiter pointers
  sa_alloc_ctrl alloc_ctrl_i (
    .clk       (clk),
    .rst_p     (rst_p),
    .weights   (weights),
    .vn_cand   (vn_cand),
    .vn_vc     (vn_vc),
    .fb_vn     (fb_vn),
    .win_valid (win_valid),
    .win_vn    (win_vn),
    .win_vc    (win_vc),
    .slot_upd  (slot_upd),
    .vn_upd    (vn_upd),
    .fb_upd    (fb_upd)
  );

  sa_grant_out grant_out_i (
    .clk         (clk),
    .rst_p       (rst_p),
    .win_valid   (win_valid),
    .win_vn      (win_vn),
    .win_vc      (win_vc),
    .slot_port   (slot_port),
    .slot_vc     (slot_vc),
    .grants      (grants),
    .vc_selected (vc_selected)
  );

endmodule

`default_nettype wire

/* dv/sa_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// Output protocol checks, bound into sa_top
module sa_checker (
  input wire logic                              clk,
  input wire logic                              rst_p,
  input wire logic                              go_phit,
  input wire logic [sa_geom_pkg::NUM_REQ-1:0]   grants
);

  // ----------------------------------------------------------------------
  // Grant vector shape
  // ----------------------------------------------------------------------
  // Never more than one winner per cycle
  a_grant_onehot: assert property (@(posedge clk) disable iff (rst_p)
    $onehot0(grants))
    else $error("grants has more than one bit set");

  // ----------------------------------------------------------------------
  // Idle rules
  // ----------------------------------------------------------------------
  // Output stage not ready, so nothing may be granted
  a_go_low_idle: assert property (@(posedge clk) disable iff (rst_p)
    !go_phit |=> (grants == '0))
    else $error("grants not zero after a cycle with go_phit low");

  a_reset_idle: assert property (@(posedge clk)
    rst_p |=> (grants == '0))                 // Covers reset and the first cycle out
    else $error("grants not zero during or right after reset");

endmodule

`default_nettype wire

/* dv/sa_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sa_tb;

  localparam int REQ_BITS = sa_geom_pkg::NUM_REQ;
  localparam int ASN_BITS = sa_geom_pkg::NUM_SLOTS * sa_geom_pkg::ASSIGN_W;
  localparam int WGT_BITS = sa_weight_pkg::WEIGHT_VEC_W;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_ENTRIES  = 24;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_ENTRIES + 20;  // Plus margin

  // Weight schedules, two bits per entry
  localparam logic [WGT_BITS-1:0] W_VN0 = 20'h00000;  // Always VN 0
  localparam logic [WGT_BITS-1:0] W_ALT = 20'h88888;  // VN 0, VN 2, VN 0 ...
  localparam logic [WGT_BITS-1:0] W_VN1 = 20'h55555;  // Always VN 1

  typedef struct {
    logic [REQ_BITS-1:0]                 req;
    logic [sa_geom_pkg::NUM_SLOTS-1:0]   sg;
    logic [ASN_BITS-1:0]                 assigns;
    logic [WGT_BITS-1:0]                 weights;
    logic                                go;
    int                                  exp_idx;  // -1 when no grant is due
    logic [sa_geom_pkg::SLOT_W-1:0]      exp_vc;   // Held value on idle cycles
  } stim_t;

  logic                              clk = 1'b0;
  logic                              rst_p;
  logic [REQ_BITS-1:0]               req;
  logic [sa_geom_pkg::NUM_SLOTS-1:0] sg;
  logic [ASN_BITS-1:0]               vc_assigns;
  logic [WGT_BITS-1:0]               weights;
  logic                              go_phit;
  logic [REQ_BITS-1:0]               grants;
  logic [sa_geom_pkg::SLOT_W-1:0]    vc_selected;

  stim_t stim [NUM_ENTRIES];
  int    fill;
  int    checks;
  int    errors;
  int    cycles = 0;

  always #2 clk = ~clk;  // 4 ns period

  sa_top sa_top_i (
    .clk         (clk),
    .rst_p       (rst_p),
    .req         (req),
    .sg          (sg),
    .vc_assigns  (vc_assigns),
    .weights     (weights),
    .go_phit     (go_phit),
    .grants      (grants),
    .vc_selected (vc_selected)
  );

  bind sa_top sa_checker checker_i (
    .clk     (clk),
    .rst_p   (rst_p),
    .go_phit (go_phit),
    .grants  (grants)
  );

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  // Owner request index per downstream slot, -1 for a free slot
  function automatic logic [ASN_BITS-1:0] pack_assigns(input int d0, input int d1,
      input int d2, input int d3, input int d4, input int d5);
    int                  own [sa_geom_pkg::NUM_SLOTS];
    logic [ASN_BITS-1:0] v;
    own = '{d0, d1, d2, d3, d4, d5};
    v   = '1;                                       // Free is all ones
    for (int d = 0; d < sa_geom_pkg::NUM_SLOTS; d++) begin
      if (own[d] >= 0) begin
        v[d*sa_geom_pkg::ASSIGN_W +: sa_geom_pkg::ASSIGN_W] = sa_geom_pkg::ASSIGN_W'(own[d]);
      end
    end
    return v;
  endfunction

  function automatic logic [REQ_BITS-1:0] req_pair(input int a, input int b);
    logic [REQ_BITS-1:0] v;
    v = '0;
    if (a >= 0) v[a] = 1'b1;
    if (b >= 0) v[b] = 1'b1;
    return v;
  endfunction

  task automatic add_entry(input logic [REQ_BITS-1:0] r, input logic [5:0] s,
      input logic [ASN_BITS-1:0] a, input logic [WGT_BITS-1:0] w, input logic g,
      input int ei, input logic [2:0] ev);
    stim[fill] = '{r, s, a, w, g, ei, ev};
    fill++;
  endtask

  // Expected values follow the round-robin, update and weight rules by hand
  task automatic build_table();
    // Idle out of reset, then port N VN0 VC0 (req 6) owning slot 3
    add_entry(req_pair(-1, -1), 6'h3F, pack_assigns(-1, -1, -1, -1, -1, -1), W_VN0, 1'b1, -1, 3'd0);
    add_entry(req_pair(6, -1), 6'h3F, pack_assigns(-1, -1, -1, 6, -1, -1), W_VN0, 1'b1, 6, 3'd3);
    // No owner, stop&go low on slot 3, go_phit low, then cleared via slot 5
    add_entry(req_pair(6, -1), 6'h3F, pack_assigns(-1, -1, -1, -1, -1, -1), W_VN0, 1'b1, -1, 3'd3);
    add_entry(req_pair(6, -1), 6'h37, pack_assigns(-1, -1, -1, 6, -1, -1), W_VN0, 1'b1, -1, 3'd3);
    add_entry(req_pair(6, -1), 6'h3F, pack_assigns(-1, -1, -1, 6, -1, -1), W_VN0, 1'b0, -1, 3'd3);
    add_entry(req_pair(6, -1), 6'h3F, pack_assigns(-1, -1, -1, -1, -1, 6), W_VN0, 1'b1, 6, 3'd5);
    // Ports L and S share VN0 VC1, lower port first
    repeat (2) begin
      add_entry(req_pair(1, 19), 6'h3F, pack_assigns(1, -1, 19, -1, -1, -1), W_VN0, 1'b1, 1, 3'd0);
      add_entry(req_pair(1, 19), 6'h3F, pack_assigns(1, -1, 19, -1, -1, -1), W_VN0, 1'b1, 19, 3'd2);
    end
    // Weight pointer at 6 here, alternating schedule wraps 9 -> 0
    add_entry(req_pair(24, 22), 6'h3F, pack_assigns(-1, 24, -1, -1, 22, -1), W_ALT, 1'b1, 24, 3'd1);
    add_entry(req_pair(24, 22), 6'h3F, pack_assigns(-1, 24, -1, -1, 22, -1), W_ALT, 1'b1, 22, 3'd4);
    add_entry(req_pair(24, 22), 6'h3F, pack_assigns(-1, 24, -1, -1, 22, -1), W_ALT, 1'b1, 24, 3'd1);
    add_entry(req_pair(24, 22), 6'h3F, pack_assigns(-1, 24, -1, -1, 22, -1), W_ALT, 1'b1, 22, 3'd4);
    add_entry(req_pair(24, 22), 6'h3F, pack_assigns(-1, 24, -1, -1, 22, -1), W_ALT, 1'b1, 24, 3'd1);
    // VN1 weighted but empty, fallback starts at VN0
    repeat (2) begin
      add_entry(req_pair(24, 22), 6'h3F, pack_assigns(-1, 24, -1, -1, 22, -1), W_VN1, 1'b1, 24, 3'd1);
      add_entry(req_pair(24, 22), 6'h3F, pack_assigns(-1, 24, -1, -1, 22, -1), W_VN1, 1'b1, 22, 3'd4);
    end
    // Port W on both VCs of VN1
    repeat (2) begin
      add_entry(req_pair(14, 15), 6'h3F, pack_assigns(14, -1, -1, -1, -1, 15), W_VN1, 1'b1, 14, 3'd0);
      add_entry(req_pair(14, 15), 6'h3F, pack_assigns(14, -1, -1, -1, -1, 15), W_VN1, 1'b1, 15, 3'd5);
    end
    add_entry(req_pair(-1, -1), 6'h3F, pack_assigns(14, -1, -1, -1, -1, 15), W_VN1, 1'b1, -1, 3'd5);
  endtask

  task automatic apply_entry(input int i);
    req        = stim[i].req;
    sg         = stim[i].sg;
    vc_assigns = stim[i].assigns;
    weights    = stim[i].weights;
    go_phit    = stim[i].go;
  endtask

  // ----------------------------------------------------------------------
  // Checking
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_entry(input int i);
    logic [31:0] exp_g;
    exp_g = (stim[i].exp_idx < 0) ? 32'd0 : (32'd1 << stim[i].exp_idx);  // One-hot
    check_value("grants", 32'(grants), exp_g);
    check_value("vc_selected", 32'(vc_selected), 32'(stim[i].exp_vc));
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d errors so far", cycles, errors);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    fill       = 0;
    checks     = 0;
    errors     = 0;
    rst_p      = 1'b1;
    req        = '0;
    sg         = '0;
    vc_assigns = '1;
    weights    = '0;
    go_phit    = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    check_value("grants", 32'(grants), 32'd0);            // Clear coming out of reset
    check_value("vc_selected", 32'(vc_selected), 32'd0);
    rst_p = 1'b0;
    apply_entry(0);
    // Result of entry i is visible one edge after it was driven
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      @(posedge clk);
      #1;
      check_entry(i);
      if (i + 1 < NUM_ENTRIES) apply_entry(i + 1);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
src/sa_geom_pkg.sv
src/sa_weight_pkg.sv
src/sa_rr_arbiter.sv
src/sa_req_filter.sv
src/sa_port_arb.sv
src/sa_vn_arb.sv
src/sa_alloc_ctrl.sv
src/sa_grant_out.sv
src/sa_top.sv
dv/sa_checker.sv
dv/sa_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= sa_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
